// ==== filelist.f ====
+incdir+rtl
rtl/icache_pkg.sv
rtl/icache_lookup_if.sv
rtl/icache_fill_if.sv
rtl/icache_ctrl.sv
rtl/icache_ways.sv
rtl/icache_line_fill.sv
rtl/icache_top.sv
sim/tb_clock_gen.sv
sim/icache_mem_model.sv
sim/icache_tb.sv

// ==== rtl/icache_ctrl.sv ====
`timescale 1ns/100ps
`include "icache_defs.svh"

module icache_ctrl (
    input  logic              clk,
    input  logic              resetn,
    input  logic              req_valid,
    output logic              req_ready,
    input  logic [31:0]       req_addr,
    input  logic              req_uncached,
    output logic              resp_valid,
    input  logic              resp_ready,
    output icache_pkg::word_t resp_data,
    icache_lookup_if.ctrl     lk,
    icache_fill_if.ctrl       fl
);
    import icache_pkg::*;

    localparam int TAG_LSB = `ICACHE_OFFSET_WIDTH + `ICACHE_INDEX_WIDTH;

    ctrl_state_t state;
    logic [31:0] addr_q;
    logic        uncached_q;
    way_t        rr_ptr;
    word_t       resp_data_q;
    word_sel_t   word_sel;
    logic        take_req;
    logic        lookup_hit;
    logic        need_fill;
    logic        fill_write;

    function automatic word_t word_of(line_t l, word_sel_t s);
        return l[s*$bits(word_t) +: $bits(word_t)];
    endfunction

    assign req_ready  = (state == IDLE);
    assign take_req   = req_valid && req_ready;
    assign word_sel   = addr_q[2 +: $bits(word_sel_t)];

    // uncached requests never take the hit path
    assign lookup_hit = (state == LOOKUP) && lk.valid_out && lk.hit && !uncached_q;
    assign need_fill  = (state == LOOKUP) && lk.valid_out && !(lk.hit && !uncached_q);
    assign fill_write = (state == FILL) && fl.done && !uncached_q;

    // index comes straight from the request while idle, so the read starts at acceptance
    assign lk.index   = (state == IDLE) ? req_addr[`ICACHE_OFFSET_WIDTH +: `ICACHE_INDEX_WIDTH]
                                        : addr_q[`ICACHE_OFFSET_WIDTH +: `ICACHE_INDEX_WIDTH];
    assign lk.tag     = addr_q[TAG_LSB +: `ICACHE_TAG_WIDTH];
    assign lk.rd_en   = take_req;
    assign lk.wr_en   = fill_write;
    assign lk.wr_way  = rr_ptr;
    assign lk.wr_line = fl.line;

    assign fl.start    = need_fill;
    assign fl.uncached = uncached_q;
    assign fl.addr     = addr_q;

    always_ff @(posedge clk) begin
        if (take_req) begin
            addr_q <= req_addr;
        end
        // response word is captured once and held through RESP
        if (lookup_hit) begin
            resp_data_q <= word_of(lk.hit_line, word_sel);
        end else if ((state == FILL) && fl.done) begin
            resp_data_q <= uncached_q ? fl.word : word_of(fl.line, word_sel);
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state      <= IDLE;
            uncached_q <= 1'b0;
            rr_ptr     <= '0;
        end else begin
            if (take_req) begin
                uncached_q <= req_uncached;
            end
            // round-robin victim advances per cached fill
            if (fill_write) begin
                rr_ptr <= rr_ptr + 1'b1;
            end
            case (state)
                IDLE: begin
                    if (take_req) begin
                        state <= LOOKUP;
                    end
                end
                LOOKUP: begin
                    if (lookup_hit) begin
                        state <= RESP;
                    end else if (need_fill) begin
                        state <= FILL;
                    end
                end
                FILL: begin
                    if (fl.done) begin
                        state <= RESP;
                    end
                end
                RESP: begin
                    if (resp_ready) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    assign resp_valid = (state == RESP);
    assign resp_data  = resp_data_q;

endmodule

// ==== rtl/icache_defs.svh ====
`ifndef ICACHE_DEFS_SVH
`define ICACHE_DEFS_SVH

// address split into tag, index and byte offset
`define ICACHE_TAG_WIDTH      20
`define ICACHE_INDEX_WIDTH    8
`define ICACHE_OFFSET_WIDTH   4

// 16-byte lines of 32-bit words
`define ICACHE_WORDS_PER_LINE 4
`define ICACHE_LINE_WIDTH     128

// associativity
`define ICACHE_WAYS           2

// memory read types
`define ICACHE_RD_TYPE_WORD   3'b010
`define ICACHE_RD_TYPE_LINE   3'b100

`endif

// ==== rtl/icache_fill_if.sv ====
`timescale 1ns/100ps

interface icache_fill_if;

    // one-cycle kick from the control stage
    logic              start;
    logic              uncached;
    logic [31:0]       addr;

    // completion pulse with returned data
    logic              done;
    icache_pkg::line_t line;
    icache_pkg::word_t word;

    modport ctrl (
        output start, uncached, addr,
        input  done, line, word
    );

    modport fill (
        input  start, uncached, addr,
        output done, line, word
    );

endinterface

// ==== rtl/icache_line_fill.sv ====
`timescale 1ns/100ps
`include "icache_defs.svh"

module icache_line_fill (
    input  logic                 clk,
    input  logic                 resetn,
    output logic                 mem_rd_req,
    output icache_pkg::rd_type_t mem_rd_type,
    output logic [31:0]          mem_rd_addr,
    input  logic                 mem_rd_rdy,
    input  logic                 mem_ret_valid,
    input  logic                 mem_ret_last,
    input  icache_pkg::word_t    mem_ret_data,
    icache_fill_if.fill          fl
);
    import icache_pkg::*;

    logic        busy;
    logic        unc_q;
    logic [31:0] addr_q;
    word_sel_t   beat;
    line_t       line_buf;
    word_t       word_q;
    logic        done_q;
    logic        beat_take;

    assign beat_take = busy && mem_ret_valid;

    // line fills go out aligned, uncached reads use the exact address
    assign mem_rd_type = unc_q ? `ICACHE_RD_TYPE_WORD : `ICACHE_RD_TYPE_LINE;
    assign mem_rd_addr = unc_q ? addr_q
                               : {addr_q[31:`ICACHE_OFFSET_WIDTH], {`ICACHE_OFFSET_WIDTH{1'b0}}};

    always_ff @(posedge clk) begin
        if (!resetn) begin
            mem_rd_req <= 1'b0;
            busy       <= 1'b0;
            unc_q      <= 1'b0;
            beat       <= '0;
            done_q     <= 1'b0;
        end else begin
            done_q <= beat_take && mem_ret_last;
            if (fl.start) begin
                mem_rd_req <= 1'b1;
                busy       <= 1'b1;
                unc_q      <= fl.uncached;
                beat       <= '0;
            end else begin
                // request drops in the cycle after ready is seen
                if (mem_rd_req && mem_rd_rdy) begin
                    mem_rd_req <= 1'b0;
                end
                if (beat_take) begin
                    beat <= beat + 1'b1;
                    if (mem_ret_last) begin
                        busy <= 1'b0;
                    end
                end
            end
        end
    end

    // beats arrive in order from word 0
    always_ff @(posedge clk) begin
        if (fl.start) begin
            addr_q <= fl.addr;
        end
        if (beat_take) begin
            if (unc_q) begin
                word_q <= mem_ret_data;
            end else begin
                line_buf[beat*$bits(word_t) +: $bits(word_t)] <= mem_ret_data;
            end
        end
    end

    assign fl.done = done_q;
    assign fl.line = line_buf;
    assign fl.word = word_q;

endmodule

// ==== rtl/icache_lookup_if.sv ====
`timescale 1ns/100ps

interface icache_lookup_if;

    // index selects the set for both read and write
    icache_pkg::index_t index;
    icache_pkg::tag_t   tag;
    logic               rd_en;

    // line write into one way
    logic               wr_en;
    icache_pkg::way_t   wr_way;
    icache_pkg::line_t  wr_line;

    // lookup result one cycle after rd_en
    logic               hit;
    icache_pkg::line_t  hit_line;
    logic               valid_out;

    modport ctrl (
        output index, tag, rd_en,
        output wr_en, wr_way, wr_line,
        input  hit, hit_line, valid_out
    );

    modport ways (
        input  index, tag, rd_en,
        input  wr_en, wr_way, wr_line,
        output hit, hit_line, valid_out
    );

endinterface

// ==== rtl/icache_pkg.sv ====
`include "icache_defs.svh"

package icache_pkg;

    // address fields
    typedef logic [`ICACHE_TAG_WIDTH-1:0]   tag_t;
    typedef logic [`ICACHE_INDEX_WIDTH-1:0] index_t;
    typedef logic [$clog2(`ICACHE_WORDS_PER_LINE)-1:0] word_sel_t;

    // payload
    typedef logic [`ICACHE_LINE_WIDTH/`ICACHE_WORDS_PER_LINE-1:0] word_t;
    typedef logic [`ICACHE_LINE_WIDTH-1:0] line_t;

    typedef logic [$clog2(`ICACHE_WAYS)-1:0] way_t;
    typedef logic [2:0] rd_type_t;

    // main control FSM
    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        FILL,
        RESP
    } ctrl_state_t;

endpackage

// ==== rtl/icache_top.sv ====
`timescale 1ns/100ps

module icache_top (
    input  logic                 clk,
    input  logic                 resetn,

    // request side
    input  logic                 req_valid,
    output logic                 req_ready,
    input  logic [31:0]          req_addr,
    input  logic                 req_uncached,

    // response side
    output logic                 resp_valid,
    input  logic                 resp_ready,
    output icache_pkg::word_t    resp_data,

    // memory read port
    output logic                 mem_rd_req,
    output icache_pkg::rd_type_t mem_rd_type,
    output logic [31:0]          mem_rd_addr,
    input  logic                 mem_rd_rdy,
    input  logic                 mem_ret_valid,
    input  logic                 mem_ret_last,
    input  icache_pkg::word_t    mem_ret_data
);

    icache_lookup_if lk_if ();
    icache_fill_if   fl_if ();

    icache_ctrl i_ctrl (
        .clk          (clk),
        .resetn       (resetn),
        .req_valid    (req_valid),
        .req_ready    (req_ready),
        .req_addr     (req_addr),
        .req_uncached (req_uncached),
        .resp_valid   (resp_valid),
        .resp_ready   (resp_ready),
        .resp_data    (resp_data),
        .lk           (lk_if.ctrl),
        .fl           (fl_if.ctrl)
    );

    icache_ways i_ways (
        .clk    (clk),
        .resetn (resetn),
        .lk     (lk_if.ways)
    );

    icache_line_fill i_line_fill (
        .clk           (clk),
        .resetn        (resetn),
        .mem_rd_req    (mem_rd_req),
        .mem_rd_type   (mem_rd_type),
        .mem_rd_addr   (mem_rd_addr),
        .mem_rd_rdy    (mem_rd_rdy),
        .mem_ret_valid (mem_ret_valid),
        .mem_ret_last  (mem_ret_last),
        .mem_ret_data  (mem_ret_data),
        .fl            (fl_if.fill)
    );

endmodule

// ==== rtl/icache_ways.sv ====
`timescale 1ns/100ps
`include "icache_defs.svh"

module icache_ways (
    input  logic          clk,
    input  logic          resetn,
    icache_lookup_if.ways lk
);
    import icache_pkg::*;

    localparam int SETS = 1 << `ICACHE_INDEX_WIDTH;

    line_t                   data_rd [`ICACHE_WAYS];
    logic [`ICACHE_WAYS-1:0] hit_way;
    logic                    rd_done;

    for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_way
        tag_t        tag_mem  [SETS];
        line_t       data_mem [SETS];
        logic [SETS-1:0] valid_bits;
        tag_t        tag_q;
        line_t       line_q;
        logic        valid_q;
        logic        wr_sel;

        assign wr_sel = lk.wr_en && (lk.wr_way == way_t'(w));

        // tag and data RAM with synchronous read
        always_ff @(posedge clk) begin
            if (wr_sel) begin
                tag_mem[lk.index]  <= lk.tag;
                data_mem[lk.index] <= lk.wr_line;
            end
            if (lk.rd_en) begin
                tag_q  <= tag_mem[lk.index];
                line_q <= data_mem[lk.index];
            end
        end

        // per-line valid bits
        always_ff @(posedge clk) begin
            if (!resetn) begin
                valid_bits <= '0;
                valid_q    <= 1'b0;
            end else begin
                if (wr_sel) begin
                    valid_bits[lk.index] <= 1'b1;
                end
                if (lk.rd_en) begin
                    valid_q <= valid_bits[lk.index];
                end
            end
        end

        assign hit_way[w] = valid_q && (tag_q == lk.tag);
        assign data_rd[w] = line_q;
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            rd_done <= 1'b0;
        end else begin
            rd_done <= lk.rd_en;
        end
    end

    assign lk.valid_out = rd_done;
    assign lk.hit       = |hit_way;

    // line of the matching way or way 0 on a miss
    always_comb begin
        lk.hit_line = data_rd[0];
        for (int w = 1; w < `ICACHE_WAYS; w++) begin
            if (hit_way[w]) begin
                lk.hit_line = data_rd[w];
            end
        end
    end

endmodule

// ==== sim/icache_mem_model.sv ====
`timescale 1ns/100ps
`include "icache_defs.svh"

module icache_mem_model (
    input  logic        clk,
    input  logic        resetn,
    input  logic        mem_rd_req,
    input  logic [2:0]  mem_rd_type,
    input  logic [31:0] mem_rd_addr,
    output logic        mem_rd_rdy,
    output logic        mem_ret_valid,
    output logic        mem_ret_last,
    output logic [31:0] mem_ret_data,
    input  logic [1:0]  rdy_delay,
    output int          req_count,
    output logic [31:0] last_addr,
    output logic [2:0]  last_type
);

    int beats;

    // every step happens 10 ns after the rising edge
    initial begin
        mem_rd_rdy    = 1'b0;
        mem_ret_valid = 1'b0;
        mem_ret_last  = 1'b0;
        mem_ret_data  = '0;
        req_count     = 0;
        last_addr     = '0;
        last_type     = '0;
        forever begin
            @(posedge clk);
            #10;
            if (resetn && mem_rd_req) begin
                req_count++;
                last_addr = mem_rd_addr;
                last_type = mem_rd_type;
                beats = (mem_rd_type == `ICACHE_RD_TYPE_LINE) ? 4 : 1;
                repeat (rdy_delay) begin
                    @(posedge clk);
                    #10;
                end
                mem_rd_rdy = 1'b1;
                @(posedge clk);
                #10;
                mem_rd_rdy = 1'b0;
                // data is the word address xor a fixed pattern
                for (int i = 0; i < beats; i++) begin
                    mem_ret_valid = 1'b1;
                    mem_ret_last  = (i == beats - 1);
                    mem_ret_data  = ((last_addr >> 2) + i) ^ 32'h5a5a0000;
                    @(posedge clk);
                    #10;
                end
                mem_ret_valid = 1'b0;
                mem_ret_last  = 1'b0;
            end
        end
    end

endmodule

// ==== sim/icache_tb.sv ====
`timescale 1ns/100ps
`include "icache_defs.svh"

module icache_tb;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_TXN      = 12;
    localparam int TIMEOUT_NS   = (RESET_CYCLES + NUM_TXN * 40) * CLK_PERIOD;

    logic        clk;
    logic        resetn;
    logic        req_valid;
    logic        req_ready;
    logic [31:0] req_addr;
    logic        req_uncached;
    logic        resp_valid;
    logic        resp_ready;
    logic [31:0] resp_data;
    logic        mem_rd_req;
    logic [2:0]  mem_rd_type;
    logic [31:0] mem_rd_addr;
    logic        mem_rd_rdy;
    logic        mem_ret_valid;
    logic        mem_ret_last;
    logic [31:0] mem_ret_data;
    logic [1:0]  rdy_delay;
    int          req_count;
    logic [31:0] last_addr;
    logic [2:0]  last_type;

    int          value_errors;
    int          protocol_errors;
    logic [15:0] lfsr_state;

    // reference view of the tag arrays
    logic [19:0] ref_tag [256][2];
    logic        ref_valid [256][2];
    logic        ref_rr;

    logic [19:0] tag_a;
    logic [7:0]  set_a;
    logic [7:0]  set_b;
    logic [1:0]  off_a;
    logic [31:0] addr_1;
    logic [31:0] addr_a;
    logic [31:0] addr_b;
    logic [31:0] addr_c;
    logic [31:0] addr_victim;
    logic [19:0] victim_tag;

    tb_clock_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) i_clk (
        .clk    (clk),
        .resetn (resetn)
    );

    icache_mem_model i_mem (
        .clk (clk), .resetn (resetn),
        .mem_rd_req (mem_rd_req), .mem_rd_type (mem_rd_type), .mem_rd_addr (mem_rd_addr),
        .mem_rd_rdy (mem_rd_rdy), .mem_ret_valid (mem_ret_valid),
        .mem_ret_last (mem_ret_last), .mem_ret_data (mem_ret_data),
        .rdy_delay (rdy_delay), .req_count (req_count),
        .last_addr (last_addr), .last_type (last_type)
    );

    icache_top i_dut (
        .clk (clk), .resetn (resetn),
        .req_valid (req_valid), .req_ready (req_ready),
        .req_addr (req_addr), .req_uncached (req_uncached),
        .resp_valid (resp_valid), .resp_ready (resp_ready), .resp_data (resp_data),
        .mem_rd_req (mem_rd_req), .mem_rd_type (mem_rd_type), .mem_rd_addr (mem_rd_addr),
        .mem_rd_rdy (mem_rd_rdy), .mem_ret_valid (mem_ret_valid),
        .mem_ret_last (mem_ret_last), .mem_ret_data (mem_ret_data)
    );

    function automatic logic [15:0] lfsr_next(logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic logic [31:0] expected_word(logic [31:0] addr);
        return (addr >> 2) ^ 32'h5a5a0000;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (exp === act) else begin
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_true(input bit cond, input string what);
        assert (cond) else begin
            $display("error at %0t ns: %s", $time, what);
            protocol_errors++;
        end
    endtask

    // one read through the request/response handshake checked against the reference
    task automatic check_access(input string name, input logic [31:0] addr,
                                input logic unc, input int stall);
        int          set;
        logic [19:0] tag;
        logic        pred_hit;
        int          count_before;
        int          cycles;
        logic [31:0] data;
        set = addr[11:4];
        tag = addr[31:12];
        pred_hit = !unc && ((ref_valid[set][0] && ref_tag[set][0] == tag) ||
                            (ref_valid[set][1] && ref_tag[set][1] == tag));
        count_before = req_count;
        check_true(req_ready === 1'b1, {name, ": req_ready low while idle"});
        rdy_delay    = 2'(rand_bits(2));
        req_addr     = addr;
        req_uncached = unc;
        req_valid    = 1'b1;
        resp_ready   = (stall == 0);
        @(posedge clk);
        #10;
        req_valid = 1'b0;
        cycles = 0;
        while (resp_valid !== 1'b1 && cycles < 40) begin
            @(posedge clk);
            #10;
            cycles++;
        end
        if (resp_valid !== 1'b1) begin
            check_true(1'b0, {name, ": no response from the cache"});
            return;
        end
        data = resp_data;
        // response must hold under back-pressure
        for (int i = 0; i < stall; i++) begin
            @(posedge clk);
            #10;
            check_true(resp_valid === 1'b1, {name, ": resp_valid dropped while stalled"});
            check_true(req_ready === 1'b0, {name, ": req_ready high while stalled"});
            check_value({name, " held data"}, data, resp_data);
        end
        resp_ready = 1'b1;
        @(posedge clk);
        #10;
        check_true(resp_valid === 1'b0, {name, ": resp_valid still high after handshake"});
        check_value({name, " data"}, expected_word(addr), data);
        if (pred_hit) begin
            check_value({name, " request count"}, count_before, req_count);
            check_value({name, " hit latency"}, 1, cycles);
        end else begin
            check_value({name, " request count"}, count_before + 1, req_count);
            check_value({name, " request addr"}, unc ? addr : {addr[31:4], 4'h0}, last_addr);
            check_value({name, " request type"},
                        unc ? `ICACHE_RD_TYPE_WORD : `ICACHE_RD_TYPE_LINE, last_type);
        end
        if (!pred_hit && !unc) begin
            ref_tag[set][ref_rr]   = tag;
            ref_valid[set][ref_rr] = 1'b1;
            ref_rr = ~ref_rr;
        end
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired after %0d ns, the cache stopped responding", TIMEOUT_NS);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        value_errors    = 0;
        protocol_errors = 0;
        lfsr_state      = 16'd8898;
        req_valid       = 1'b0;
        req_addr        = '0;
        req_uncached    = 1'b0;
        resp_ready      = 1'b1;
        rdy_delay       = '0;
        ref_rr          = 1'b0;
        for (int s = 0; s < 256; s++) begin
            ref_valid[s][0] = 1'b0;
            ref_valid[s][1] = 1'b0;
        end
        wait (resetn === 1'b1);
        @(posedge clk);
        #10;
        check_true(req_ready === 1'b1, "req_ready low after reset");
        check_true(resp_valid === 1'b0, "resp_valid high after reset");
        check_true(mem_rd_req === 1'b0, "mem_rd_req high after reset");

        // cached miss then hits on the same line
        tag_a  = 20'(rand_bits(20));
        set_a  = 8'(rand_bits(8));
        off_a  = 2'(rand_bits(2));
        addr_1 = {tag_a, set_a, off_a, 2'b00};
        check_access("cached miss", addr_1, 1'b0, 0);
        check_access("line hit", addr_1, 1'b0, 0);
        check_access("line hit other word", {addr_1[31:4], ~addr_1[3:2], 2'b00}, 1'b0, 0);

        // three tags in one set
        tag_a = 20'(rand_bits(20));
        set_b = 8'(rand_bits(8));
        if (set_b == set_a) begin
            set_b = set_b ^ 8'h01;
        end
        addr_a = {tag_a, set_b, 2'(rand_bits(2)), 2'b00};
        addr_b = {tag_a ^ 20'h1, set_b, 2'(rand_bits(2)), 2'b00};
        addr_c = {tag_a ^ 20'h2, set_b, 2'(rand_bits(2)), 2'b00};
        check_access("set fill a", addr_a, 1'b0, 0);
        check_access("set fill b", addr_b, 1'b0, 0);
        check_access("set hit a", addr_a, 1'b0, 0);
        check_access("set hit b", addr_b, 1'b0, 0);
        victim_tag  = ref_tag[set_b][ref_rr];
        addr_victim = (victim_tag == addr_a[31:12]) ? addr_a : addr_b;
        check_access("evict with c", addr_c, 1'b0, 0);
        check_access("evicted tag reread", addr_victim, 1'b0, 0);

        // uncached reads at an odd word
        addr_1 = {20'(rand_bits(20)), 8'(rand_bits(8)), 1'(rand_bits(1)), 1'b1, 2'b00};
        check_access("uncached read", addr_1, 1'b1, 0);
        check_access("uncached repeat", addr_1, 1'b1, 0);

        // back-pressure on a hit
        check_access("stalled hit", addr_c, 1'b0, 1 + int'(rand_bits(3)));

        $display("errors: %0d value, %0d protocol", value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== sim/tb_clock_gen.sv ====
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int PERIOD       = 100,
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic resetn
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // reset released a little after the edge like the rest of the stimulus
    initial begin
        resetn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #10 resetn = 1'b1;
    end

endmodule
